//--- include/cache_axi_defines.svh
`ifndef CACHE_AXI_DEFINES_SVH
`define CACHE_AXI_DEFINES_SVH

// bus and line geometry
`define DATA_BITS   32          // one AXI beat
`define ADDR_BITS   32          // byte address
`define LINE_BITS   512         // one cache line
`define BEATS       16          // beats per line

// on-chip SRAM behind the bridge
`define MEM_WORDS   1024        // word depth, wraps at 4 KB

`define AXI_ID_BITS 4           // read source tag

`endif

//--- src/cache_axi_pkg.sv
`include "cache_axi_defines.svh"

package cache_axi_pkg;

    typedef logic [`DATA_BITS-1:0]       word_t;      // one beat
    typedef logic [`ADDR_BITS-1:0]       addr_t;      // byte address
    typedef logic [`LINE_BITS-1:0]       line_t;      // full line
    typedef logic [`DATA_BITS/8-1:0]     strb_t;      // byte lanes
    typedef logic [$clog2(`BEATS)-1:0]   beat_cnt_t;  // beat index in a line
    typedef logic [`AXI_ID_BITS-1:0]     axi_id_t;    // 0 instr, 1 data

    typedef enum logic [2:0] {
        R_IDLE,
        R_IADDR,
        R_IDATA,
        R_DADDR,
        R_DDATA
    } rd_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_RESP
    } slv_state_t;

endpackage

//--- src/line_assembler.sv
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module line_assembler (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  cache_axi_pkg::word_t                i_beat,
    input  logic                                i_beat_en,
    input  logic                                i_flush,
    output logic [`LINE_BITS-`DATA_BITS-1:0]    o_partial
);

    localparam int PART_BITS = `LINE_BITS - `DATA_BITS;

    cache_axi_pkg::beat_cnt_t           cnt;
    logic                               full;
    logic [PART_BITS-1:0]               buf_q;

    assign full = (cnt == cache_axi_pkg::beat_cnt_t'(`BEATS - 1));   // 15 words held

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            cnt <= '0;
        else if (i_flush)
            cnt <= '0;
        else if (i_beat_en && !full)
            cnt <= cnt + 1'b1;
    end

    // newest beat enters at word 14, oldest ends up in word 0
    always_ff @(posedge aclk)
    begin
        if (i_flush)
            buf_q <= '0;
        else if (i_beat_en && !full)
            buf_q <= {i_beat, buf_q[PART_BITS-1:`DATA_BITS]};
    end

    assign o_partial = buf_q;

endmodule

//--- src/line_serializer.sv
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module line_serializer (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  cache_axi_pkg::line_t    i_line,
    input  cache_axi_pkg::strb_t    i_strb,
    input  logic                    i_load,
    input  logic                    i_advance,
    output cache_axi_pkg::word_t    o_beat,
    output cache_axi_pkg::strb_t    o_strb,
    output logic                    o_last
);

    cache_axi_pkg::line_t       line_q;
    cache_axi_pkg::strb_t       strb_q;
    cache_axi_pkg::beat_cnt_t   cnt;

    // line and strobe held for the whole burst
    always_ff @(posedge aclk)
    begin
        if (i_load)
        begin
            line_q <= i_line;
            strb_q <= i_strb;
        end
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            cnt <= '0;
        else if (i_load)
            cnt <= '0;              // restart at word 0
        else if (i_advance)
            cnt <= cnt + 1'b1;      // accepted beats only
    end

    assign o_beat = line_q[`DATA_BITS*cnt +: `DATA_BITS];   // lowest word first
    assign o_strb = strb_q;
    assign o_last = (cnt == cache_axi_pkg::beat_cnt_t'(`BEATS - 1));

endmodule

//--- src/cache_axi_bridge.sv
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module cache_axi_bridge (
    input  logic                        aclk,
    input  logic                        aresetn,
    // instruction read port
    input  cache_axi_pkg::addr_t        i_i_raddr,
    input  logic                        i_i_rvalid,
    output cache_axi_pkg::line_t        o_i_rdata,
    output logic                        o_i_rready,
    // data read port
    input  cache_axi_pkg::addr_t        i_d_raddr,
    input  logic                        i_d_rvalid,
    output cache_axi_pkg::line_t        o_d_rdata,
    output logic                        o_d_rready,
    // data write-back port
    input  cache_axi_pkg::addr_t        i_d_waddr,
    input  cache_axi_pkg::line_t        i_d_wdata,
    input  cache_axi_pkg::strb_t        i_d_wstrb,
    input  logic                        i_d_wvalid,
    output logic                        o_d_wready,
    // AXI AR and R
    output cache_axi_pkg::axi_id_t      o_arid,
    output cache_axi_pkg::addr_t        o_araddr,
    output logic                        o_arvalid,
    input  logic                        i_arready,
    input  cache_axi_pkg::word_t        i_rdata,
    input  logic                        i_rlast,
    input  logic                        i_rvalid,
    output logic                        o_rready,
    // AXI AW, W and B
    output cache_axi_pkg::addr_t        o_awaddr,
    output logic                        o_awvalid,
    input  logic                        i_awready,
    output cache_axi_pkg::word_t        o_wdata,
    output cache_axi_pkg::strb_t        o_wstrb,
    output logic                        o_wlast,
    output logic                        o_wvalid,
    input  logic                        i_wready,
    input  logic                        i_bvalid,
    output logic                        o_bready
);

    localparam int OFFS = $clog2(`LINE_BITS / 8);   // line offset bits, ignored

    cache_axi_pkg::rd_state_t           rd_state, rd_next;
    cache_axi_pkg::wr_state_t           wr_state, wr_next;
    logic [`LINE_BITS-`DATA_BITS-1:0]   partial;
    cache_axi_pkg::line_t               line_in;
    logic                               r_beat, r_done;
    logic                               ser_load;

    assign r_beat  = i_rvalid & o_rready;
    assign r_done  = r_beat & i_rlast;
    assign line_in = {i_rdata, partial};            // final beat is word 15

    line_assembler u_asm (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_beat    (i_rdata),
        .i_beat_en (r_beat),
        .i_flush   (r_done),
        .o_partial (partial)
    );

    assign o_i_rdata = line_in;
    assign o_d_rdata = line_in;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            rd_state <= cache_axi_pkg::R_IDLE;
            wr_state <= cache_axi_pkg::W_IDLE;
        end
        else
        begin
            rd_state <= rd_next;
            wr_state <= wr_next;
        end
    end

    // read side, data port has priority
    always_comb
    begin
        rd_next    = rd_state;
        o_arvalid  = 1'b0;
        o_arid     = '0;
        o_araddr   = {i_i_raddr[`ADDR_BITS-1:OFFS], OFFS'(0)};
        o_rready   = 1'b0;
        o_i_rready = 1'b0;
        o_d_rready = 1'b0;
        case (rd_state)
            cache_axi_pkg::R_IDLE:
            begin
                if (i_d_rvalid)
                begin
                    o_arvalid = 1'b1;
                    o_arid    = cache_axi_pkg::axi_id_t'(1);
                    o_araddr  = {i_d_raddr[`ADDR_BITS-1:OFFS], OFFS'(0)};
                    rd_next   = i_arready ? cache_axi_pkg::R_DDATA : cache_axi_pkg::R_DADDR;
                end
                else if (i_i_rvalid)
                begin
                    o_arvalid = 1'b1;
                    rd_next   = i_arready ? cache_axi_pkg::R_IDATA : cache_axi_pkg::R_IADDR;
                end
            end
            cache_axi_pkg::R_IADDR:
            begin
                o_arvalid = 1'b1;
                if (i_arready)
                    rd_next = cache_axi_pkg::R_IDATA;
            end
            cache_axi_pkg::R_IDATA:
            begin
                o_rready   = 1'b1;
                o_i_rready = r_done;            // one-cycle pulse
                if (r_done)
                    rd_next = cache_axi_pkg::R_IDLE;
            end
            cache_axi_pkg::R_DADDR:
            begin
                o_arvalid = 1'b1;
                o_arid    = cache_axi_pkg::axi_id_t'(1);
                o_araddr  = {i_d_raddr[`ADDR_BITS-1:OFFS], OFFS'(0)};
                if (i_arready)
                    rd_next = cache_axi_pkg::R_DDATA;
            end
            cache_axi_pkg::R_DDATA:
            begin
                o_rready   = 1'b1;
                o_d_rready = r_done;
                if (r_done)
                    rd_next = cache_axi_pkg::R_IDLE;
            end
            default:
                rd_next = cache_axi_pkg::R_IDLE;
        endcase
    end

    line_serializer u_ser (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_line    (i_d_wdata),
        .i_strb    (i_d_wstrb),
        .i_load    (ser_load),
        .i_advance (o_wvalid & i_wready),
        .o_beat    (o_wdata),
        .o_strb    (o_wstrb),
        .o_last    (o_wlast)
    );

    assign o_awaddr = {i_d_waddr[`ADDR_BITS-1:OFFS], OFFS'(0)};

    // write side, address then 16 beats then response
    always_comb
    begin
        wr_next    = wr_state;
        o_awvalid  = 1'b0;
        o_wvalid   = 1'b0;
        o_bready   = 1'b0;
        o_d_wready = 1'b0;
        ser_load   = 1'b0;
        case (wr_state)
            cache_axi_pkg::W_IDLE:
            begin
                if (i_d_wvalid)
                begin
                    o_awvalid = 1'b1;
                    ser_load  = 1'b1;           // capture line with the address
                    wr_next   = i_awready ? cache_axi_pkg::W_DATA : cache_axi_pkg::W_ADDR;
                end
            end
            cache_axi_pkg::W_ADDR:
            begin
                o_awvalid = 1'b1;
                if (i_awready)
                    wr_next = cache_axi_pkg::W_DATA;
            end
            cache_axi_pkg::W_DATA:
            begin
                o_wvalid = 1'b1;
                if (i_wready && o_wlast)
                    wr_next = cache_axi_pkg::W_RESP;
            end
            cache_axi_pkg::W_RESP:
            begin
                o_bready   = 1'b1;
                o_d_wready = i_bvalid;          // pulse on B handshake
                if (i_bvalid)
                    wr_next = cache_axi_pkg::W_IDLE;
            end
            default:
                wr_next = cache_axi_pkg::W_IDLE;
        endcase
    end

endmodule

//--- src/axi_sram_slave.sv
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module axi_sram_slave (
    input  logic                        aclk,
    input  logic                        aresetn,
    // AR and R
    input  cache_axi_pkg::axi_id_t      i_arid,
    input  cache_axi_pkg::addr_t        i_araddr,
    input  logic                        i_arvalid,
    output logic                        o_arready,
    output cache_axi_pkg::word_t        o_rdata,
    output logic                        o_rlast,
    output logic                        o_rvalid,
    input  logic                        i_rready,
    // AW, W and B
    input  cache_axi_pkg::addr_t        i_awaddr,
    input  logic                        i_awvalid,
    output logic                        o_awready,
    input  cache_axi_pkg::word_t        i_wdata,
    input  cache_axi_pkg::strb_t        i_wstrb,
    input  logic                        i_wlast,
    input  logic                        i_wvalid,
    output logic                        o_wready,
    output logic                        o_bvalid,
    input  logic                        i_bready
);

    localparam int WA_BITS = $clog2(`MEM_WORDS);   // word address bits 11 to 2
    localparam cache_axi_pkg::beat_cnt_t LAST_BEAT = cache_axi_pkg::beat_cnt_t'(`BEATS - 1);

    cache_axi_pkg::word_t       mem [`MEM_WORDS];
    cache_axi_pkg::slv_state_t  state;
    logic [WA_BITS-1:0]         waddr_q;            // burst word pointer
    cache_axi_pkg::beat_cnt_t   beat;
    logic                       ar_hs, aw_hs, r_hs, w_hs;

    // AW wins over AR when both wait in idle
    assign o_awready = (state == cache_axi_pkg::S_IDLE);
    assign o_arready = (state == cache_axi_pkg::S_IDLE) && !i_awvalid;
    assign o_rvalid  = (state == cache_axi_pkg::S_READ);
    assign o_wready  = (state == cache_axi_pkg::S_WRITE);
    assign o_bvalid  = (state == cache_axi_pkg::S_RESP);

    assign aw_hs = i_awvalid & o_awready;
    assign ar_hs = i_arvalid & o_arready;
    assign r_hs  = o_rvalid & i_rready;
    assign w_hs  = i_wvalid & o_wready;

    assign o_rdata = mem[waddr_q];
    assign o_rlast = (beat == LAST_BEAT);

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state   <= cache_axi_pkg::S_IDLE;
            waddr_q <= '0;
            beat    <= '0;
        end
        else
        begin
            case (state)
                cache_axi_pkg::S_IDLE:
                begin
                    beat <= '0;
                    if (aw_hs)
                    begin
                        waddr_q <= i_awaddr[WA_BITS+1:2];
                        state   <= cache_axi_pkg::S_WRITE;
                    end
                    else if (ar_hs)
                    begin
                        waddr_q <= i_araddr[WA_BITS+1:2];
                        state   <= cache_axi_pkg::S_READ;
                    end
                end
                cache_axi_pkg::S_READ:
                begin
                    if (r_hs)
                    begin
                        waddr_q <= waddr_q + 1'b1;      // INCR, one word per beat
                        beat    <= beat + 1'b1;
                        if (o_rlast)
                            state <= cache_axi_pkg::S_IDLE;
                    end
                end
                cache_axi_pkg::S_WRITE:
                begin
                    if (w_hs)
                    begin
                        waddr_q <= waddr_q + 1'b1;
                        beat    <= beat + 1'b1;
                        if (i_wlast)
                            state <= cache_axi_pkg::S_RESP;
                    end
                end
                cache_axi_pkg::S_RESP:
                begin
                    if (i_bready)
                        state <= cache_axi_pkg::S_IDLE;
                end
                default:
                    state <= cache_axi_pkg::S_IDLE;
            endcase
        end
    end

    // byte-lane write, no reset on the array
    always_ff @(posedge aclk)
    begin
        if (w_hs)
        begin
            for (int b = 0; b < `DATA_BITS / 8; b++)
            begin
                if (i_wstrb[b])
                    mem[waddr_q][8*b +: 8] <= i_wdata[8*b +: 8];
            end
        end
    end

endmodule

//--- src/cache_mem_top.sv
`timescale 1ns/1ps

module cache_mem_top (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  cache_axi_pkg::addr_t    i_i_raddr,
    input  logic                    i_i_rvalid,
    output cache_axi_pkg::line_t    o_i_rdata,
    output logic                    o_i_rready,
    input  cache_axi_pkg::addr_t    i_d_raddr,
    input  logic                    i_d_rvalid,
    output cache_axi_pkg::line_t    o_d_rdata,
    output logic                    o_d_rready,
    input  cache_axi_pkg::addr_t    i_d_waddr,
    input  cache_axi_pkg::line_t    i_d_wdata,
    input  cache_axi_pkg::strb_t    i_d_wstrb,
    input  logic                    i_d_wvalid,
    output logic                    o_d_wready
);

    cache_axi_pkg::axi_id_t     arid;
    cache_axi_pkg::addr_t       araddr, awaddr;
    cache_axi_pkg::word_t       rdata, wdata;
    cache_axi_pkg::strb_t       wstrb;
    logic                       arvalid, arready, rlast, rvalid, rready;
    logic                       awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    cache_axi_bridge u_bridge (
        .aclk       (aclk),         .aresetn    (aresetn),
        .i_i_raddr  (i_i_raddr),    .i_i_rvalid (i_i_rvalid),
        .o_i_rdata  (o_i_rdata),    .o_i_rready (o_i_rready),
        .i_d_raddr  (i_d_raddr),    .i_d_rvalid (i_d_rvalid),
        .o_d_rdata  (o_d_rdata),    .o_d_rready (o_d_rready),
        .i_d_waddr  (i_d_waddr),    .i_d_wdata  (i_d_wdata),
        .i_d_wstrb  (i_d_wstrb),    .i_d_wvalid (i_d_wvalid),
        .o_d_wready (o_d_wready),
        .o_arid     (arid),         .o_araddr   (araddr),
        .o_arvalid  (arvalid),      .i_arready  (arready),
        .i_rdata    (rdata),        .i_rlast    (rlast),
        .i_rvalid   (rvalid),       .o_rready   (rready),
        .o_awaddr   (awaddr),       .o_awvalid  (awvalid),
        .i_awready  (awready),      .o_wdata    (wdata),
        .o_wstrb    (wstrb),        .o_wlast    (wlast),
        .o_wvalid   (wvalid),       .i_wready   (wready),
        .i_bvalid   (bvalid),       .o_bready   (bready)
    );

    axi_sram_slave u_sram (
        .aclk      (aclk),      .aresetn   (aresetn),
        .i_arid    (arid),      .i_araddr  (araddr),
        .i_arvalid (arvalid),   .o_arready (arready),
        .o_rdata   (rdata),     .o_rlast   (rlast),
        .o_rvalid  (rvalid),    .i_rready  (rready),
        .i_awaddr  (awaddr),    .i_awvalid (awvalid),
        .o_awready (awready),   .i_wdata   (wdata),
        .i_wstrb   (wstrb),     .i_wlast   (wlast),
        .i_wvalid  (wvalid),    .o_wready  (wready),
        .o_bvalid  (bvalid),    .i_bready  (bready)
    );

endmodule

//--- testbench/tb_cache_mem.sv
`timescale 1ns/1ps
`include "cache_axi_defines.svh"

module tb_cache_mem;

    localparam int TIMEOUT = 200;           // cycles per wait
    localparam int MAX_ENT = 20;

    typedef enum int {OP_WRITE, OP_DREAD, OP_IREAD, OP_BOTH} op_t;

    logic                   aclk;
    logic                   aresetn;
    cache_axi_pkg::addr_t   i_i_raddr, i_d_raddr, i_d_waddr;
    logic                   i_i_rvalid, i_d_rvalid, i_d_wvalid;
    cache_axi_pkg::line_t   o_i_rdata, o_d_rdata, i_d_wdata;
    cache_axi_pkg::strb_t   i_d_wstrb;
    logic                   o_i_rready, o_d_rready, o_d_wready;

    // stimulus table, one column per array
    op_t                    ops    [MAX_ENT];
    cache_axi_pkg::addr_t   addrs  [MAX_ENT];
    cache_axi_pkg::addr_t   addrs2 [MAX_ENT];      // instruction address for OP_BOTH
    cache_axi_pkg::strb_t   strbs  [MAX_ENT];
    string                  names  [MAX_ENT];
    int                     num_ent;

    cache_axi_pkg::word_t   shadow [`MEM_WORDS];   // expected memory contents
    cache_axi_pkg::line_t   wr_line, got_d, got_i;
    int unsigned            seed;

    cache_mem_top dut (
        .aclk       (aclk),         .aresetn    (aresetn),
        .i_i_raddr  (i_i_raddr),    .i_i_rvalid (i_i_rvalid),
        .o_i_rdata  (o_i_rdata),    .o_i_rready (o_i_rready),
        .i_d_raddr  (i_d_raddr),    .i_d_rvalid (i_d_rvalid),
        .o_d_rdata  (o_d_rdata),    .o_d_rready (o_d_rready),
        .i_d_waddr  (i_d_waddr),    .i_d_wdata  (i_d_wdata),
        .i_d_wstrb  (i_d_wstrb),    .i_d_wvalid (i_d_wvalid),
        .o_d_wready (o_d_wready)
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic add_entry(input op_t op, input cache_axi_pkg::addr_t a,
                             input cache_axi_pkg::addr_t a2, input cache_axi_pkg::strb_t s,
                             input string name);
        ops[num_ent]    = op;
        addrs[num_ent]  = a;
        addrs2[num_ent] = a2;
        strbs[num_ent]  = s;
        names[num_ent]  = name;
        num_ent++;
    endtask

    // first shadow word of the line, 4 KB wrap and low 6 bits dropped
    function automatic int line_base(input cache_axi_pkg::addr_t a);
        return ((a >> 2) % `MEM_WORDS) / `BEATS * `BEATS;
    endfunction

    task automatic check_line(input string name, input cache_axi_pkg::addr_t a,
                              input cache_axi_pkg::line_t got);
        int base;
        cache_axi_pkg::word_t exp_w;
        cache_axi_pkg::word_t got_w;
        base = line_base(a);
        for (int k = 0; k < `BEATS; k++)
        begin
            exp_w = shadow[base + k];
            got_w = got[`DATA_BITS*k +: `DATA_BITS];
            assert (got_w === exp_w)
            else fail_stop($sformatf("Error: %s word %0d expected %h actual %h",
                                     name, k, exp_w, got_w));
        end
    endtask

    task automatic do_write(input string name, input cache_axi_pkg::addr_t a,
                            input cache_axi_pkg::strb_t s);
        int n;
        int base;
        for (int k = 0; k < `BEATS; k++)
            wr_line[`DATA_BITS*k +: `DATA_BITS] = $urandom;
        @(negedge aclk);
        i_d_waddr  = a;
        i_d_wdata  = wr_line;
        i_d_wstrb  = s;
        i_d_wvalid = 1'b1;
        n = 0;
        @(negedge aclk);
        while (!o_d_wready && n < TIMEOUT)
        begin
            @(negedge aclk);
            n++;
        end
        if (!o_d_wready)
            fail_stop($sformatf("%s: write port never answered with o_d_wready", name));
        i_d_wvalid = 1'b0;                  // drop after the pulse
        base = line_base(a);
        for (int k = 0; k < `BEATS; k++)    // byte merge into the shadow
            for (int b = 0; b < `DATA_BITS / 8; b++)
                if (s[b])
                    shadow[base + k][8*b +: 8] = wr_line[`DATA_BITS*k + 8*b +: 8];
    endtask

    task automatic do_read(input string name, input bit is_data,
                           input cache_axi_pkg::addr_t a);
        int n;
        @(negedge aclk);
        if (is_data)
        begin
            i_d_raddr  = a;
            i_d_rvalid = 1'b1;
        end
        else
        begin
            i_i_raddr  = a;
            i_i_rvalid = 1'b1;
        end
        n = 0;
        @(negedge aclk);
        while (!(is_data ? o_d_rready : o_i_rready) && n < TIMEOUT)
        begin
            @(negedge aclk);
            n++;
        end
        if (is_data && !o_d_rready)
            fail_stop($sformatf("%s: data read port never answered", name));
        if (!is_data && !o_i_rready)
            fail_stop($sformatf("%s: instruction read port never answered", name));
        got_d      = is_data ? o_d_rdata : o_i_rdata;   // rdata valid only now
        i_d_rvalid = 1'b0;
        i_i_rvalid = 1'b0;
        check_line(name, a, got_d);
    endtask

    // both ports in the same cycle, data must answer first
    task automatic do_both(input string name, input cache_axi_pkg::addr_t ad,
                           input cache_axi_pkg::addr_t ai);
        int n;
        bit d_done;
        bit i_done;
        @(negedge aclk);
        i_d_raddr  = ad;
        i_i_raddr  = ai;
        i_d_rvalid = 1'b1;
        i_i_rvalid = 1'b1;
        d_done = 1'b0;
        i_done = 1'b0;
        n = 0;
        while (!(d_done && i_done) && n < TIMEOUT)
        begin
            @(negedge aclk);
            n++;
            if (o_i_rready && !i_done)
            begin
                assert (d_done)
                else fail_stop($sformatf("%s: instruction port answered before data port",
                                         name));
                got_i      = o_i_rdata;
                i_i_rvalid = 1'b0;
                i_done     = 1'b1;
            end
            if (o_d_rready && !d_done)
            begin
                got_d      = o_d_rdata;
                i_d_rvalid = 1'b0;
                d_done     = 1'b1;
            end
        end
        if (!d_done)
            fail_stop($sformatf("%s: data read port never answered", name));
        if (!i_done)
            fail_stop($sformatf("%s: instruction read port never answered", name));
        check_line({name, "_d"}, ad, got_d);
        check_line({name, "_i"}, ai, got_i);
    endtask

    initial
    begin
        seed       = $urandom(89);          // seeds the generator once
        aresetn    = 1'b0;
        i_i_raddr  = '0;
        i_i_rvalid = 1'b0;
        i_d_raddr  = '0;
        i_d_rvalid = 1'b0;
        i_d_waddr  = '0;
        i_d_wdata  = '0;
        i_d_wstrb  = '0;
        i_d_wvalid = 1'b0;
        num_ent    = 0;

        add_entry(OP_WRITE, 32'h0000_0100, '0, 4'hF, "write_a_full");
        add_entry(OP_DREAD, 32'h0000_0100, '0, '0,   "dread_a");
        add_entry(OP_IREAD, 32'h0000_0100, '0, '0,   "iread_a");
        add_entry(OP_WRITE, 32'h0000_0140, '0, 4'hF, "write_b_full");
        add_entry(OP_WRITE, 32'h0000_0140, '0, 4'h5, "write_b_strb5");
        add_entry(OP_DREAD, 32'h0000_0140, '0, '0,   "dread_b_merge");
        add_entry(OP_WRITE, 32'h0000_0100, '0, 4'h8, "write_a_strb8");
        add_entry(OP_IREAD, 32'h0000_0100, '0, '0,   "iread_a_merge");
        add_entry(OP_DREAD, 32'h0000_0108, '0, '0,   "dread_a_offset");
        add_entry(OP_WRITE, 32'h0000_0200, '0, 4'hF, "write_c");
        add_entry(OP_WRITE, 32'h0000_1200, '0, 4'hF, "write_c_alias");
        add_entry(OP_DREAD, 32'h0000_0200, '0, '0,   "dread_c_wrap");
        add_entry(OP_DREAD, 32'h0000_1200, '0, '0,   "dread_c_alias");
        add_entry(OP_BOTH,  32'h0000_0140, 32'h0000_0100, '0, "both_reads_1");
        add_entry(OP_WRITE, 32'h0000_3FC0, '0, 4'hF, "write_top");
        add_entry(OP_IREAD, 32'h0000_0FC0, '0, '0,   "iread_top_wrap");
        add_entry(OP_BOTH,  32'h0000_0200, 32'h0000_0FC0, '0, "both_reads_2");

        repeat (8) @(negedge aclk);
        aresetn = 1'b1;

        // idle after reset, nothing may answer
        repeat (10)
        begin
            @(negedge aclk);
            assert (!o_i_rready && !o_d_rready && !o_d_wready)
            else fail_stop("a client ready pulsed after reset with no request pending");
        end

        for (int e = 0; e < num_ent; e++)
        begin
            case (ops[e])
                OP_WRITE: do_write(names[e], addrs[e], strbs[e]);
                OP_DREAD: do_read(names[e], 1'b1, addrs[e]);
                OP_IREAD: do_read(names[e], 1'b0, addrs[e]);
                default:  do_both(names[e], addrs[e], addrs2[e]);
            endcase
        end

        repeat (4) @(negedge aclk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
src/cache_axi_pkg.sv
src/line_assembler.sv
src/line_serializer.sv
src/cache_axi_bridge.sv
src/axi_sram_slave.sv
src/cache_mem_top.sv
testbench/tb_cache_mem.sv

//--- Bender.yml
package:
  name: cache_mem

sources:
  - include_dirs:
      - include
    files:
      - src/cache_axi_pkg.sv
      - src/line_assembler.sv
      - src/line_serializer.sv
      - src/cache_axi_bridge.sv
      - src/axi_sram_slave.sv
      - src/cache_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_cache_mem.sv
